// File: vlog.f
cpu_pkg.sv
pipe_if.sv
alu.sv
regfile.sv
controller.sv
pc.sv
forward.sv
regwalls.sv
top.sv
top_asserts.sv
tb_top.sv

// File: tb_top.sv
`timescale 1ns/1ns

module tb_top import cpu_pkg::*; ();

	logic     clk;
	logic     arst_n;
	word_t    instruction;
	logic     alu_overflow;
	logic     im_read;
	pc_t      im_address;
	logic     dm_read;
	logic     dm_write;
	dm_addr_t dm_address;
	word_t    dm_in;
	word_t    dm_out;

	word_t    imem [1024];
	word_t    dmem [4096];
	word_t    prog [1024];
	int       plen;
	dm_addr_t exp_addr [$];
	word_t    exp_data [$];
	string    test_name;
	int       ovf_cycles;
	int       cycle_count;
	int       cycle_limit = 20;
	int       seed = 32'h7d73_883e;

	top #(
		.NUM_REGS(32),
		.RESET_PC('0)
	) DUT (
		.clk(clk),
		.arst_n(arst_n),
		.instruction(instruction),
		.alu_overflow(alu_overflow),
		.im_read(im_read),
		.im_address(im_address),
		.dm_read(dm_read),
		.dm_write(dm_write),
		.dm_address(dm_address),
		.dm_in(dm_in),
		.dm_out(dm_out)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// both memories answer in the same cycle
	assign instruction = imem[im_address];
	// load data only on the read strobe
	assign dm_out      = dm_read ? dmem[dm_address] : '0;

	always @(posedge clk) begin
		if (arst_n && dm_write)
			dmem[dm_address] <= dm_in;
	end

	function automatic word_t fill_word(int addr);
		return (addr * 32'h9e37_79b9) ^ 32'hc3a5_0f0f;
	endfunction

	task automatic load_memories();
		for (int k = 0; k < 1024; k++)
			imem[k] = (k < plen) ? prog[k] : '0;
		for (int k = 0; k < 4096; k++)
			dmem[k] = fill_word(k);
	endtask

	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_addr(string name, dm_addr_t exp, dm_addr_t act);
		if (exp !== act) begin
			$display("FAILED %s store address: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_word(string name, word_t exp, word_t act);
		if (exp !== act) begin
			$display("FAILED %s store data: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (exp !== act) begin
			$display("FAILED %s overflow cycles: expected %0d, actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	// instruction-set model that queues the expected stores
	function automatic int iss_run(output int steps);
		word_t    r [32];
		word_t    m [4096];
		insn_t    i;
		pc_t      p;
		word_t    a;
		word_t    b;
		word_t    res;
		word_t    simm;
		longint   s;
		int       ovf;
		logic     done;
		for (int k = 0; k < 32; k++)
			r[k] = '0;
		for (int k = 0; k < 4096; k++)
			m[k] = fill_word(k);
		exp_addr.delete();
		exp_data.delete();
		p = '0;
		ovf = 0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < 20000) begin
			i = prog[p];
			steps++;
			a = r[i.i_fmt.ra];
			simm = $signed(i.i_fmt.imm);
			case (i.i_fmt.opcode)
				OP_ALU: begin
					b = r[i.r_fmt.rb];
					s = 0;
					case (i.r_fmt.sub_op)
						SUB_ADD: s = longint'($signed(a)) + longint'($signed(b));
						SUB_SUB: s = longint'($signed(a)) - longint'($signed(b));
						SUB_AND: s = a & b;
						SUB_OR:  s = a | b;
						SUB_XOR: s = a ^ b;
						default: s = 0;
					endcase
					res = s[31:0];
					if ((i.r_fmt.sub_op == SUB_ADD || i.r_fmt.sub_op == SUB_SUB) &&
						s != longint'($signed(res)))
						ovf++;
					r[i.r_fmt.rt] = res;
					p++;
				end
				OP_ADDI: begin
					s = longint'($signed(a)) + longint'($signed(simm));
					res = s[31:0];
					if (s != longint'($signed(res)))
						ovf++;
					r[i.i_fmt.rt] = res;
					p++;
				end
				OP_MOVI: begin
					res = i;
					r[i.i_fmt.rt] = $signed(res[19:0]);
					p++;
				end
				OP_LWI: begin
					res = a + simm;
					r[i.i_fmt.rt] = m[res[11:0]];
					p++;
				end
				OP_SWI: begin
					res = a + simm;
					m[res[11:0]] = r[i.i_fmt.rt];
					exp_addr.push_back(res[11:0]);
					exp_data.push_back(r[i.i_fmt.rt]);
					p++;
				end
				OP_BR: begin
					if ((r[i.i_fmt.rt] == a) != i.i_fmt.imm[14])
						p = p + i.i_fmt.imm[9:0];
					else
						p++;
				end
				OP_J: begin
					res = i;
					if (res[23:0] == '0)
						done = 1'b1;
					else
						p = p + res[9:0];
				end
				default: p++;
			endcase
		end
		return ovf;
	endfunction

	task automatic append_insn(word_t w);
		prog[plen] = w;
		plen++;
	endtask

	task automatic alu_op(sub_op_t sub, int rt, int ra, int rb);
		insn_t x;
		x = '0;
		x.r_fmt.opcode = OP_ALU;
		x.r_fmt.rt = rt;
		x.r_fmt.ra = ra;
		x.r_fmt.rb = rb;
		x.r_fmt.sub_op = sub;
		append_insn(x);
	endtask

	task automatic imm_op(opcode_t op, int rt, int ra, int imm);
		insn_t x;
		x = '0;
		x.i_fmt.opcode = op;
		x.i_fmt.rt = rt;
		x.i_fmt.ra = ra;
		x.i_fmt.imm = imm[14:0];
		append_insn(x);
	endtask

	task automatic move_imm(int rt, int imm);
		insn_t x;
		x = '0;
		x.i_fmt.opcode = OP_MOVI;
		x.i_fmt.rt = rt;
		{x.i_fmt.ra, x.i_fmt.imm} = imm[19:0];
		append_insn(x);
	endtask

	task automatic branch_to(bit ne, int rt, int ra, int off);
		imm_op(OP_BR, rt, ra, {ne, off[13:0]});
	endtask

	task automatic jump_by(int off);
		word_t w;
		w = '0;
		w[30:25] = OP_J;
		w[23:0] = off[23:0];
		append_insn(w);
	endtask

	function automatic int pick_below(int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	// program in prog ends with a jump to itself
	task automatic run_program(string name);
		int steps;
		int exp_ovf;
		int last_seen;
		int cyc;
		test_name = name;
		exp_ovf = iss_run(steps);
		cycle_limit += steps * 4 + 110;
		@(negedge clk);
		arst_n = 1'b0;
		ovf_cycles = 0;
		load_memories();
		repeat (10) @(negedge clk);
		arst_n = 1'b1;
		// final self-jump fetched twice, two cycles apart
		last_seen = -10;
		cyc = 0;
		forever begin
			@(negedge clk);
			cyc++;
			if (im_address == pc_t'(plen - 1)) begin
				if (cyc - last_seen == 2)
					break;
				last_seen = cyc;
			end
		end
		repeat (4) @(posedge clk);
		if (exp_addr.size() != 0) begin
			$display("%s: %0d expected stores never happened", name, exp_addr.size());
			abort_run();
		end
		check_count(name, exp_ovf, ovf_cycles);
		plen = 0;
	endtask

	always @(posedge clk) begin
		if (arst_n === 1'b1) begin
			if (alu_overflow)
				ovf_cycles++;
			if (dm_write) begin
				if (exp_addr.size() == 0) begin
					$display("%s: unexpected store to %h", test_name, dm_address);
					abort_run();
				end else begin
					check_addr(test_name, exp_addr.pop_front(), dm_address);
					check_word(test_name, exp_data.pop_front(), dm_in);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout in %s after %0d cycles", test_name, cycle_count);
			abort_run();
		end
	end

	initial begin
		int loop_pc;
		int off;
		arst_n = 1'b0;
		plen = 0;
		cycle_count = 0;
		load_memories();

		move_imm(1, -1234);
		move_imm(2, 77777);
		imm_op(OP_ADDI, 3, 1, -100);
		alu_op(SUB_ADD, 4, 1, 2);
		alu_op(SUB_SUB, 5, 1, 2);
		alu_op(SUB_AND, 6, 1, 2);
		alu_op(SUB_OR, 7, 1, 2);
		alu_op(SUB_XOR, 8, 1, 2);
		for (int k = 1; k <= 8; k++)
			imm_op(OP_SWI, k, 0, 16 + k);
		jump_by(0);
		run_program("alu");

		move_imm(1, 5);
		alu_op(SUB_ADD, 2, 1, 1);
		move_imm(9, 7);
		alu_op(SUB_ADD, 3, 2, 9);
		move_imm(10, 1);
		move_imm(11, 2);
		alu_op(SUB_XOR, 4, 3, 10);
		imm_op(OP_SWI, 4, 0, 34);
		imm_op(OP_SWI, 2, 0, 32);
		imm_op(OP_SWI, 3, 0, 33);
		jump_by(0);
		run_program("forwarding");

		move_imm(1, 100);
		imm_op(OP_SWI, 1, 0, 40);
		imm_op(OP_LWI, 2, 0, 40);
		alu_op(SUB_ADD, 3, 2, 2);
		imm_op(OP_SWI, 3, 0, 50);
		imm_op(OP_LWI, 4, 0, 40);
		branch_to(0, 4, 1, 2);
		imm_op(OP_SWI, 1, 0, 51);
		imm_op(OP_SWI, 4, 0, 52);
		imm_op(OP_LWI, 5, 0, 7);
		alu_op(SUB_ADD, 6, 5, 5);
		imm_op(OP_SWI, 6, 0, 53);
		jump_by(0);
		run_program("load_use");

		move_imm(1, 0);
		move_imm(2, 3);
		loop_pc = plen;
		imm_op(OP_ADDI, 1, 1, 1);
		imm_op(OP_SWI, 1, 0, 60);
		branch_to(1, 1, 2, loop_pc - plen);
		branch_to(0, 1, 2, 2);
		imm_op(OP_SWI, 2, 0, 61);
		branch_to(1, 1, 2, 2);
		imm_op(OP_SWI, 1, 0, 62);
		jump_by(2);
		imm_op(OP_SWI, 1, 0, 63);
		branch_to(0, 1, 0, 2);
		imm_op(OP_SWI, 2, 0, 64);
		jump_by(0);
		run_program("control_flow");

		// doubling 2^18 thirteen times reaches the most negative word
		move_imm(1, 1 << 18);
		for (int k = 0; k < 13; k++)
			alu_op(SUB_ADD, 1, 1, 1);
		move_imm(2, -1);
		alu_op(SUB_ADD, 3, 1, 2);
		alu_op(SUB_ADD, 4, 1, 2);
		alu_op(SUB_SUB, 5, 1, 2);
		alu_op(SUB_SUB, 6, 4, 2);
		imm_op(OP_ADDI, 7, 3, 1);
		for (int k = 1; k <= 7; k++)
			imm_op(OP_SWI, k, 0, 70 + k);
		jump_by(0);
		run_program("overflow");

		for (int k = 0; k < 200; k++) begin
			off = 1 + pick_below(4);
			if (off > 200 - k)
				off = 200 - k;
			case (pick_below(8))
				0, 1: alu_op(sub_op_t'(pick_below(5)), pick_below(8), pick_below(8),
					pick_below(8));
				2: imm_op(OP_ADDI, pick_below(8), pick_below(8), pick_below(2000) - 1000);
				3: move_imm(pick_below(8), pick_below(1 << 20) - (1 << 19));
				4: imm_op(OP_LWI, pick_below(8), pick_below(8), pick_below(64));
				5: imm_op(OP_SWI, pick_below(8), pick_below(8), pick_below(64));
				6: branch_to(pick_below(2), pick_below(8), pick_below(8), off);
				default: jump_by(off);
			endcase
		end
		jump_by(0);
		run_program("random");

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: top_asserts.sv
`timescale 1ns/1ns

module top_asserts (
	input logic clk,
	input logic arst_n,
	input logic im_read,
	input logic dm_read,
	input logic dm_write
);

	// a memory-stage instruction is either a load or a store
	assert property (@(posedge clk) disable iff (!arst_n) !(dm_read && dm_write))
		else $error("dm_read and dm_write high together");

	assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({im_read, dm_read, dm_write}))
		else $error("memory strobe unknown");

	assert property (@(posedge clk) arst_n |-> im_read)
		else $error("im_read low out of reset");

endmodule

bind top top_asserts u_top_asserts (
	.clk(clk),
	.arst_n(arst_n),
	.im_read(im_read),
	.dm_read(dm_read),
	.dm_write(dm_write)
);

// File: top.sv
`timescale 1ns/1ns

module top import cpu_pkg::*; #(
	parameter int  NUM_REGS = 32,
	parameter pc_t RESET_PC = '0
) (
	input  logic     clk,
	input  logic     arst_n,
	input  word_t    instruction,
	output logic     alu_overflow,
	output logic     im_read,
	output pc_t      im_address,
	output logic     dm_read,
	output logic     dm_write,
	output dm_addr_t dm_address,
	output word_t    dm_in,
	input  word_t    dm_out
);

	pipe_if ex_w ();
	pipe_if mem_w ();
	pipe_if wb_w ();

	insn_t   dec_insn;
	pc_t     dec_pc;
	pc_t     current_pc;
	logic    flush;
	logic    hazard;
	word_t   ra_data;
	word_t   rb_data;
	word_t   rt_data;
	word_t   f_ra_data;
	word_t   f_rb_data;
	word_t   f_rt_data;
	logic    do_reg_write;
	logic    do_dm_read;
	logic    do_dm_write;
	wb_sel_t wb_sel;
	logic    use_rb;
	logic    uses_ra;
	logic    uses_rt;
	word_t   operand_b;
	opcode_t ex_opcode;
	sub_op_t ex_sub_op;
	word_t   ex_operand_a;
	word_t   ex_operand_b;
	word_t   alu_result;

	// fetch runs every cycle out of reset
	assign im_read    = arst_n;
	assign im_address = current_pc;

	pc #(
		.RESET_PC(RESET_PC)
	) u_pc (
		.clk(clk),
		.arst_n(arst_n),
		.stall(hazard),
		.insn(dec_insn),
		.decode_pc(dec_pc),
		.ra_data(f_ra_data),
		.rt_data(f_rt_data),
		.current_pc(current_pc),
		.flush(flush)
	);

	regfile #(
		.NUM_REGS(NUM_REGS)
	) u_regfile (
		.clk(clk),
		.arst_n(arst_n),
		.ra_addr(dec_insn.r_fmt.ra),
		.rb_addr(dec_insn.r_fmt.rb),
		.rt_addr(dec_insn.r_fmt.rt),
		.wb(wb_w.fwd),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.rt_data(rt_data)
	);

	controller u_controller (
		.insn(dec_insn),
		.rb_data(f_rb_data),
		.do_reg_write(do_reg_write),
		.do_dm_read(do_dm_read),
		.do_dm_write(do_dm_write),
		.wb_sel(wb_sel),
		.use_rb(use_rb),
		.operand_b(operand_b),
		.uses_ra(uses_ra),
		.uses_rt(uses_rt)
	);

	forward u_forward (
		.ra_addr(dec_insn.r_fmt.ra),
		.rb_addr(dec_insn.r_fmt.rb),
		.rt_addr(dec_insn.r_fmt.rt),
		.uses_ra(uses_ra),
		.use_rb(use_rb),
		.uses_rt(uses_rt),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.rt_data(rt_data),
		.ex_w(ex_w.fwd),
		.mem_w(mem_w.fwd),
		.wb_w(wb_w.fwd),
		.f_ra_data(f_ra_data),
		.f_rb_data(f_rb_data),
		.f_rt_data(f_rt_data),
		.hazard(hazard)
	);

	alu u_alu (
		.operand_a(ex_operand_a),
		.operand_b(ex_operand_b),
		.opcode(ex_opcode),
		.sub_op(ex_sub_op),
		.result(alu_result),
		.overflow(alu_overflow)
	);

	regwalls u_regwalls (
		.clk(clk),
		.arst_n(arst_n),
		.instruction(instruction),
		.current_pc(current_pc),
		.flush(flush),
		.hazard(hazard),
		.dec_insn(dec_insn),
		.dec_pc(dec_pc),
		.do_reg_write(do_reg_write),
		.do_dm_read(do_dm_read),
		.do_dm_write(do_dm_write),
		.wb_sel(wb_sel),
		.f_ra_data(f_ra_data),
		.operand_b(operand_b),
		.f_rt_data(f_rt_data),
		.alu_result(alu_result),
		.ex_opcode(ex_opcode),
		.ex_sub_op(ex_sub_op),
		.ex_operand_a(ex_operand_a),
		.ex_operand_b(ex_operand_b),
		.dm_read(dm_read),
		.dm_write(dm_write),
		.dm_address(dm_address),
		.dm_in(dm_in),
		.dm_out(dm_out),
		.ex_w(ex_w.wall),
		.mem_w(mem_w.wall),
		.wb_w(wb_w.wall)
	);

endmodule

// File: regwalls.sv
`timescale 1ns/1ns

module regwalls import cpu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  word_t    instruction,
	input  pc_t      current_pc,
	input  logic     flush,
	input  logic     hazard,
	output insn_t    dec_insn,
	output pc_t      dec_pc,
	input  logic     do_reg_write,
	input  logic     do_dm_read,
	input  logic     do_dm_write,
	input  wb_sel_t  wb_sel,
	input  word_t    f_ra_data,
	input  word_t    operand_b,
	input  word_t    f_rt_data,
	input  word_t    alu_result,
	output opcode_t  ex_opcode,
	output sub_op_t  ex_sub_op,
	output word_t    ex_operand_a,
	output word_t    ex_operand_b,
	output logic     dm_read,
	output logic     dm_write,
	output dm_addr_t dm_address,
	output word_t    dm_in,
	input  word_t    dm_out,
	pipe_if.wall     ex_w,
	pipe_if.wall     mem_w,
	pipe_if.wall     wb_w
);

	logic    ex_dm_write;
	wb_sel_t ex_wb_sel;
	word_t   ex_store_data;
	wb_sel_t mem_wb_sel;
	word_t   mem_alu_result;

	assign ex_w.write_data  = alu_result;
	assign mem_w.write_data = (mem_wb_sel == WB_MEM) ? dm_out : mem_alu_result;
	assign dm_read          = mem_w.is_load;
	assign dm_address       = mem_alu_result[11:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_insn             <= '0;
			dec_pc               <= '0;
			ex_opcode            <= '0;
			ex_sub_op            <= '0;
			ex_dm_write          <= 1'b0;
			ex_wb_sel            <= WB_ALU;
			ex_w.do_reg_write    <= 1'b0;
			ex_w.is_load         <= 1'b0;
			ex_w.write_reg_addr  <= '0;
			dm_write             <= 1'b0;
			mem_wb_sel           <= WB_ALU;
			mem_w.do_reg_write   <= 1'b0;
			mem_w.is_load        <= 1'b0;
			mem_w.write_reg_addr <= '0;
			wb_w.do_reg_write    <= 1'b0;
			wb_w.is_load         <= 1'b0;
			wb_w.write_reg_addr  <= '0;
		end else begin
			// fetch wall holds on a load-use stall
			if (!hazard) begin
				dec_insn <= flush ? '0 : instruction;
				dec_pc   <= current_pc;
			end
			// decode wall takes a bubble instead
			ex_opcode           <= hazard ? '0 : dec_insn.r_fmt.opcode;
			ex_sub_op           <= dec_insn.r_fmt.sub_op;
			ex_dm_write         <= do_dm_write && !hazard;
			ex_wb_sel           <= wb_sel;
			ex_w.do_reg_write   <= do_reg_write && !hazard;
			ex_w.is_load        <= do_dm_read && !hazard;
			ex_w.write_reg_addr <= dec_insn.r_fmt.rt;
			dm_write             <= ex_dm_write;
			mem_wb_sel           <= ex_wb_sel;
			mem_w.do_reg_write   <= ex_w.do_reg_write;
			mem_w.is_load        <= ex_w.is_load;
			mem_w.write_reg_addr <= ex_w.write_reg_addr;
			wb_w.do_reg_write    <= mem_w.do_reg_write;
			wb_w.is_load         <= mem_w.is_load;
			wb_w.write_reg_addr  <= mem_w.write_reg_addr;
		end
	end

	always_ff @(posedge clk) begin
		ex_operand_a    <= f_ra_data;
		ex_operand_b    <= operand_b;
		ex_store_data   <= f_rt_data;
		mem_alu_result  <= alu_result;
		dm_in           <= ex_store_data;
		wb_w.write_data <= mem_w.write_data;
	end

endmodule

// File: forward.sv
`timescale 1ns/1ns

module forward import cpu_pkg::*; (
	input  reg_addr_t ra_addr,
	input  reg_addr_t rb_addr,
	input  reg_addr_t rt_addr,
	input  logic      uses_ra,
	input  logic      use_rb,
	input  logic      uses_rt,
	input  word_t     ra_data,
	input  word_t     rb_data,
	input  word_t     rt_data,
	pipe_if.fwd       ex_w,
	pipe_if.fwd       mem_w,
	pipe_if.fwd       wb_w,
	output word_t     f_ra_data,
	output word_t     f_rb_data,
	output word_t     f_rt_data,
	output logic      hazard
);

	// later checks override, so execute wins over memory and write-back
	function automatic word_t pick(reg_addr_t addr, word_t rf_data);
		word_t data;
		data = rf_data;
		if (wb_w.do_reg_write && wb_w.write_reg_addr == addr)
			data = wb_w.write_data;
		if (mem_w.do_reg_write && mem_w.write_reg_addr == addr)
			data = mem_w.write_data;
		if (ex_w.do_reg_write && ex_w.write_reg_addr == addr)
			data = ex_w.write_data;
		return data;
	endfunction

	always_comb begin
		f_ra_data = pick(ra_addr, ra_data);
		f_rb_data = pick(rb_addr, rb_data);
		f_rt_data = pick(rt_addr, rt_data);
	end

	// load data only exists once the load reaches memory
	assign hazard = ex_w.is_load && ex_w.do_reg_write &&
		((uses_ra && ex_w.write_reg_addr == ra_addr) ||
		(use_rb && ex_w.write_reg_addr == rb_addr) ||
		(uses_rt && ex_w.write_reg_addr == rt_addr));

endmodule

// File: pc.sv
`timescale 1ns/1ns

module pc import cpu_pkg::*; #(
	parameter pc_t RESET_PC = '0
) (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  stall,
	input  insn_t insn,
	input  pc_t   decode_pc,
	input  word_t ra_data,
	input  word_t rt_data,
	output pc_t   current_pc,
	output logic  flush
);

	word_t offset;
	logic  redirect;
	pc_t   target;

	always_comb begin
		offset   = {{18{insn.i_fmt.imm[13]}}, insn.i_fmt.imm[13:0]};
		redirect = 1'b0;
		if (insn.i_fmt.opcode == OP_BR) begin
			// sense bit clear means branch on equal
			redirect = (rt_data == ra_data) ^ insn.i_fmt.imm[14];
		end else if (insn.i_fmt.opcode == OP_J) begin
			offset   = {{8{insn.i_fmt.rt[3]}}, insn.i_fmt.rt[3:0], insn.i_fmt.ra, insn.i_fmt.imm};
			redirect = 1'b1;
		end
	end

	assign target = decode_pc + offset[9:0];
	// operands may be stale while a load-use stall is pending
	assign flush  = redirect && !stall;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			current_pc <= RESET_PC;
		end else if (flush) begin
			current_pc <= target;
		end else if (!stall) begin
			current_pc <= current_pc + 1'b1;
		end
	end

endmodule

// File: controller.sv
`timescale 1ns/1ns

module controller import cpu_pkg::*; (
	input  insn_t   insn,
	input  word_t   rb_data,
	output logic    do_reg_write,
	output logic    do_dm_read,
	output logic    do_dm_write,
	output wb_sel_t wb_sel,
	output logic    use_rb,
	output word_t   operand_b,
	output logic    uses_ra,
	output logic    uses_rt
);

	word_t imm;

	always_comb begin
		do_reg_write = 1'b0;
		do_dm_read   = 1'b0;
		do_dm_write  = 1'b0;
		wb_sel       = WB_ALU;
		use_rb       = 1'b0;
		uses_ra      = 1'b0;
		uses_rt      = 1'b0;
		imm          = {{17{insn.i_fmt.imm[14]}}, insn.i_fmt.imm};
		case (insn.r_fmt.opcode)
			OP_ALU: begin
				do_reg_write = 1'b1;
				use_rb       = 1'b1;
				uses_ra      = 1'b1;
			end
			OP_ADDI: begin
				do_reg_write = 1'b1;
				uses_ra      = 1'b1;
			end
			OP_MOVI: begin
				do_reg_write = 1'b1;
				// 20-bit immediate spans the ra field
				imm = {{12{insn.i_fmt.ra[4]}}, insn.i_fmt.ra, insn.i_fmt.imm};
			end
			OP_LWI: begin
				do_reg_write = 1'b1;
				do_dm_read   = 1'b1;
				wb_sel       = WB_MEM;
				uses_ra      = 1'b1;
			end
			OP_SWI: begin
				do_dm_write = 1'b1;
				uses_ra     = 1'b1;
				uses_rt     = 1'b1;
			end
			// compared in decode by the pc block
			OP_BR: begin
				uses_ra = 1'b1;
				uses_rt = 1'b1;
			end
			default: ;
		endcase
	end

	assign operand_b = use_rb ? rb_data : imm;

endmodule

// File: regfile.sv
`timescale 1ns/1ns

module regfile import cpu_pkg::*; #(
	parameter int NUM_REGS = 32
) (
	input  logic      clk,
	input  logic      arst_n,
	input  reg_addr_t ra_addr,
	input  reg_addr_t rb_addr,
	input  reg_addr_t rt_addr,
	pipe_if.fwd       wb,
	output word_t     ra_data,
	output word_t     rb_data,
	output word_t     rt_data
);

	word_t regs [NUM_REGS];

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.do_reg_write) begin
			regs[wb.write_reg_addr] <= wb.write_data;
		end
	end

endmodule

// File: alu.sv
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
	input  word_t   operand_a,
	input  word_t   operand_b,
	input  opcode_t opcode,
	input  sub_op_t sub_op,
	output word_t   result,
	output logic    overflow
);

	logic is_add;
	logic is_sub;

	always_comb begin
		result = '0;
		is_add = 1'b0;
		is_sub = 1'b0;
		case (opcode)
			OP_ADDI: begin
				result = operand_a + operand_b;
				is_add = 1'b1;
			end
			// address generation never flags overflow
			OP_LWI, OP_SWI: result = operand_a + operand_b;
			OP_MOVI: result = operand_b;
			OP_ALU: begin
				case (sub_op)
					SUB_ADD: begin
						result = operand_a + operand_b;
						is_add = 1'b1;
					end
					SUB_SUB: begin
						result = operand_a - operand_b;
						is_sub = 1'b1;
					end
					SUB_AND: result = operand_a & operand_b;
					SUB_OR:  result = operand_a | operand_b;
					SUB_XOR: result = operand_a ^ operand_b;
					default: result = '0;
				endcase
			end
			default: result = '0;
		endcase
	end

	// sign of result disagrees with the operand signs
	assign overflow =
		(is_add && operand_a[31] == operand_b[31] && result[31] != operand_a[31]) ||
		(is_sub && operand_a[31] != operand_b[31] && result[31] != operand_a[31]);

endmodule

// File: pipe_if.sv
`timescale 1ns/1ns

// pending register write of one pipeline stage
interface pipe_if import cpu_pkg::*; ();

	logic      do_reg_write;
	logic      is_load;
	reg_addr_t write_reg_addr;
	word_t     write_data;

	modport wall (
		output do_reg_write,
		output is_load,
		output write_reg_addr,
		output write_data
	);

	modport fwd (
		input do_reg_write,
		input is_load,
		input write_reg_addr,
		input write_data
	);

endinterface

// File: cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [9:0]  pc_t;
	typedef logic [11:0] dm_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [4:0]  sub_op_t;
	typedef logic [1:0]  wb_sel_t;

	// opcode zero is never issued and acts as a bubble
	localparam opcode_t OP_ALU  = 6'b100000;
	localparam opcode_t OP_ADDI = 6'b101000;
	localparam opcode_t OP_MOVI = 6'b100010;
	localparam opcode_t OP_LWI  = 6'b000010;
	localparam opcode_t OP_SWI  = 6'b001010;
	localparam opcode_t OP_BR   = 6'b100110;
	localparam opcode_t OP_J    = 6'b100100;

	localparam sub_op_t SUB_ADD = 5'd0;
	localparam sub_op_t SUB_SUB = 5'd1;
	localparam sub_op_t SUB_AND = 5'd2;
	localparam sub_op_t SUB_XOR = 5'd3;
	localparam sub_op_t SUB_OR  = 5'd4;

	localparam wb_sel_t WB_ALU = 2'd0;
	localparam wb_sel_t WB_MEM = 2'd1;

	typedef union packed {
		struct packed {
			logic       spare;
			opcode_t    opcode;
			reg_addr_t  rt;
			reg_addr_t  ra;
			reg_addr_t  rb;
			logic [4:0] spare_lo;
			sub_op_t    sub_op;
		} r_fmt;
		struct packed {
			logic        spare;
			opcode_t     opcode;
			reg_addr_t   rt;
			reg_addr_t   ra;
			logic [14:0] imm;
		} i_fmt;
	} insn_t;

endpackage
